// File: source/rv_core_pkg.sv
//--------------------------------------
// rv_core shared types
// widths, opcodes, alu operations and
// the two views of an instruction word
//--------------------------------------
`default_nettype none

package rv_core_pkg;

  localparam int xlen = 64;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] reg_addr_t;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111
  } opcode_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_pass_b
  } alu_op_t;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    opcode_t    opcode;
  } r_view_t;

  // store and branch immediates split around rs1/rs2
  typedef struct packed {
    logic [6:0] imm_hi;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_t    opcode;
  } s_view_t;

  typedef union packed {
    r_view_t r_view;
    s_view_t s_view;
  } instr_t;

  // addi x0, x0, 0
  localparam logic [31:0] nop_word = 32'h0000_0013;

endpackage

`default_nettype wire

// File: source/fetch_unit.sv
//--------------------------------------
// fetch unit
// pc, instruction memory with a load
// port, stall hold and redirect
//--------------------------------------
`timescale 1ns/1ns
`default_nettype none

module fetch_unit #(
  parameter int imem_words = 256,
  parameter rv_core_pkg::word_t reset_pc = '0
) (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          run,
  input  logic                          prog_write,
  input  logic [$clog2(imem_words)-1:0] prog_addr,
  input  logic [31:0]                   prog_data,
  input  logic                          stall,
  input  logic                          redirect,
  input  rv_core_pkg::word_t            redirect_pc,
  output logic                          fetch_valid,
  output rv_core_pkg::word_t            fetch_pc,
  output rv_core_pkg::instr_t           fetch_instr
);

  localparam int imem_aw = $clog2(imem_words);

  logic [31:0] imem [imem_words];
  logic [31:0] instr_q;
  rv_core_pkg::word_t pc;

  always_ff @(posedge clock) begin
    if (prog_write) begin
      imem[prog_addr] <= prog_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= reset_pc;
      fetch_valid <= 1'b0;
    end else if (redirect) begin
      pc <= redirect_pc;
      fetch_valid <= 1'b0;
    end else if (!stall) begin
      fetch_valid <= run;
      if (run) begin
        pc <= pc + 64'd4;
      end
    end
  end

  // synchronous read, held while decode stalls
  always_ff @(posedge clock) begin
    if (!stall && run) begin
      instr_q <= imem[pc[imem_aw+1:2]];
      fetch_pc <= pc;
    end
  end

  assign fetch_instr = fetch_valid ? rv_core_pkg::instr_t'(instr_q)
                                   : rv_core_pkg::instr_t'(rv_core_pkg::nop_word);

endmodule

`default_nettype wire

// File: source/register_file.sv
//--------------------------------------
// register file
// 32 x 64-bit, x0 reads as zero,
// write-through to the read ports
//--------------------------------------
`timescale 1ns/1ns
`default_nettype none

module register_file (
  input  logic                   clock,
  input  logic                   reset,
  input  rv_core_pkg::reg_addr_t rs1,
  input  rv_core_pkg::reg_addr_t rs2,
  input  logic                   wb_write,
  input  rv_core_pkg::reg_addr_t wb_rd,
  input  rv_core_pkg::word_t     wb_data,
  output rv_core_pkg::word_t     rs1_data,
  output rv_core_pkg::word_t     rs2_data
);

  rv_core_pkg::word_t regs [32];

  always_ff @(posedge clock) begin
    if (reset) begin
      regs <= '{default: '0};
    end else if (wb_write && wb_rd != 5'd0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // same-cycle writeback bypass
  assign rs1_data = (wb_write && wb_rd == rs1 && rs1 != 5'd0) ? wb_data : regs[rs1];
  assign rs2_data = (wb_write && wb_rd == rs2 && rs2 != 5'd0) ? wb_data : regs[rs2];

endmodule

`default_nettype wire

// File: source/decode_unit.sv
//--------------------------------------
// decode unit
// field decode, immediates, load-use
// stall and the decode/execute register
//--------------------------------------
`timescale 1ns/1ns
`default_nettype none

module decode_unit (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   fetch_valid,
  input  rv_core_pkg::word_t     fetch_pc,
  input  rv_core_pkg::instr_t    fetch_instr,
  input  rv_core_pkg::word_t     rs1_data,
  input  rv_core_pkg::word_t     rs2_data,
  input  logic                   redirect,
  output rv_core_pkg::reg_addr_t rs1,
  output rv_core_pkg::reg_addr_t rs2,
  output logic                   stall,
  output logic                   ex_valid,
  output rv_core_pkg::word_t     ex_pc,
  output rv_core_pkg::alu_op_t   ex_alu_op,
  output rv_core_pkg::word_t     ex_op_a,
  output rv_core_pkg::word_t     ex_op_b,
  output rv_core_pkg::word_t     ex_imm,
  output logic                   ex_use_rs1,
  output logic                   ex_use_rs2,
  output rv_core_pkg::reg_addr_t ex_rs1,
  output rv_core_pkg::reg_addr_t ex_rs2,
  output rv_core_pkg::reg_addr_t ex_rd,
  output logic                   ex_rd_write,
  output logic                   ex_is_load,
  output logic                   ex_is_store,
  output logic                   ex_is_branch,
  output logic                   ex_branch_ne,
  output logic                   ex_is_jal
);

  rv_core_pkg::r_view_t r;
  rv_core_pkg::s_view_t s;
  rv_core_pkg::word_t imm_i;
  rv_core_pkg::word_t imm_s;
  rv_core_pkg::word_t imm_b;
  rv_core_pkg::word_t imm_u;
  rv_core_pkg::word_t imm_j;
  rv_core_pkg::word_t d_imm;
  rv_core_pkg::alu_op_t funct_op;
  rv_core_pkg::alu_op_t d_alu_op;
  logic d_use_rs1;
  logic d_use_rs2;
  logic d_rd_write;
  logic d_is_load;
  logic d_is_store;
  logic d_is_branch;
  logic d_is_jal;
  logic bubble;

  assign r = fetch_instr.r_view;
  assign s = fetch_instr.s_view;
  assign rs1 = r.rs1;
  assign rs2 = r.rs2;

  assign imm_i = {{52{r.funct7[6]}}, r.funct7, r.rs2};
  assign imm_s = {{52{s.imm_hi[6]}}, s.imm_hi, s.imm_lo};
  assign imm_b = {{52{s.imm_hi[6]}}, s.imm_lo[0], s.imm_hi[5:0], s.imm_lo[4:1], 1'b0};
  assign imm_u = {{32{fetch_instr[31]}}, fetch_instr[31:12], 12'd0};
  assign imm_j = {{44{fetch_instr[31]}}, fetch_instr[19:12], fetch_instr[20],
                  fetch_instr[30:21], 1'b0};

  always_comb begin
    case (r.funct3)
      3'b111:  funct_op = rv_core_pkg::alu_and;
      3'b110:  funct_op = rv_core_pkg::alu_or;
      3'b100:  funct_op = rv_core_pkg::alu_xor;
      3'b010:  funct_op = rv_core_pkg::alu_slt;
      default: funct_op = rv_core_pkg::alu_add;
    endcase
  end

  always_comb begin
    d_alu_op = rv_core_pkg::alu_add;
    d_imm = imm_i;
    d_use_rs1 = 1'b0;
    d_use_rs2 = 1'b0;
    d_rd_write = 1'b0;
    d_is_load = 1'b0;
    d_is_store = 1'b0;
    d_is_branch = 1'b0;
    d_is_jal = 1'b0;
    case (r.opcode)
      rv_core_pkg::opc_lui: begin
        d_alu_op = rv_core_pkg::alu_pass_b;
        d_imm = imm_u;
        d_rd_write = 1'b1;
      end
      rv_core_pkg::opc_op_imm: begin
        d_alu_op = funct_op;
        d_use_rs1 = 1'b1;
        d_rd_write = 1'b1;
      end
      rv_core_pkg::opc_op: begin
        d_alu_op = (r.funct3 == 3'b000 && r.funct7[5]) ? rv_core_pkg::alu_sub : funct_op;
        d_use_rs1 = 1'b1;
        d_use_rs2 = 1'b1;
        d_rd_write = 1'b1;
      end
      rv_core_pkg::opc_load: begin
        d_use_rs1 = 1'b1;
        d_rd_write = 1'b1;
        d_is_load = 1'b1;
      end
      // rs2 carries the store data through operand b
      rv_core_pkg::opc_store: begin
        d_imm = imm_s;
        d_use_rs1 = 1'b1;
        d_use_rs2 = 1'b1;
        d_is_store = 1'b1;
      end
      rv_core_pkg::opc_branch: begin
        d_imm = imm_b;
        d_use_rs1 = 1'b1;
        d_use_rs2 = 1'b1;
        d_is_branch = 1'b1;
      end
      rv_core_pkg::opc_jal: begin
        d_imm = imm_j;
        d_rd_write = 1'b1;
        d_is_jal = 1'b1;
      end
      default: ;
    endcase
  end

  // load in execute feeding this instruction
  assign stall = fetch_valid && ex_is_load && ex_rd_write &&
                 ((d_use_rs1 && rs1 == ex_rd) || (d_use_rs2 && rs2 == ex_rd));
  assign bubble = stall || redirect || !fetch_valid;

  always_ff @(posedge clock) begin
    if (reset || bubble) begin
      ex_valid <= 1'b0;
      ex_rd_write <= 1'b0;
      ex_is_load <= 1'b0;
      ex_is_store <= 1'b0;
      ex_is_branch <= 1'b0;
      ex_is_jal <= 1'b0;
    end else begin
      ex_valid <= 1'b1;
      ex_rd_write <= d_rd_write && r.rd != 5'd0;
      ex_is_load <= d_is_load;
      ex_is_store <= d_is_store;
      ex_is_branch <= d_is_branch;
      ex_is_jal <= d_is_jal;
    end
  end

  always_ff @(posedge clock) begin
    ex_pc <= fetch_pc;
    ex_alu_op <= d_alu_op;
    ex_op_a <= rs1_data;
    ex_op_b <= d_use_rs2 ? rs2_data : d_imm;
    ex_imm <= d_imm;
    ex_use_rs1 <= d_use_rs1;
    ex_use_rs2 <= d_use_rs2;
    ex_rs1 <= rs1;
    ex_rs2 <= rs2;
    ex_rd <= r.rd;
    ex_branch_ne <= r.funct3[0];
  end

endmodule

`default_nettype wire

// File: source/execute_unit.sv
//--------------------------------------
// execute unit
// forwarding, alu, branch resolution
// and the execute/memory register
//--------------------------------------
`timescale 1ns/1ns
`default_nettype none

module execute_unit (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   ex_valid,
  input  rv_core_pkg::word_t     ex_pc,
  input  rv_core_pkg::alu_op_t   ex_alu_op,
  input  rv_core_pkg::word_t     ex_op_a,
  input  rv_core_pkg::word_t     ex_op_b,
  input  rv_core_pkg::word_t     ex_imm,
  input  logic                   ex_use_rs1,
  input  logic                   ex_use_rs2,
  input  rv_core_pkg::reg_addr_t ex_rs1,
  input  rv_core_pkg::reg_addr_t ex_rs2,
  input  rv_core_pkg::reg_addr_t ex_rd,
  input  logic                   ex_rd_write,
  input  logic                   ex_is_load,
  input  logic                   ex_is_store,
  input  logic                   ex_is_branch,
  input  logic                   ex_branch_ne,
  input  logic                   ex_is_jal,
  input  logic                   wb_write,
  input  rv_core_pkg::reg_addr_t wb_rd,
  input  rv_core_pkg::word_t     wb_data,
  output logic                   redirect,
  output rv_core_pkg::word_t     redirect_pc,
  output logic                   mem_valid,
  output rv_core_pkg::word_t     mem_pc,
  output rv_core_pkg::reg_addr_t mem_rd,
  output logic                   mem_rd_write,
  output logic                   mem_is_load,
  output logic                   mem_is_store,
  output rv_core_pkg::word_t     mem_result,
  output rv_core_pkg::word_t     mem_store_data
);

  rv_core_pkg::word_t alu_a;
  rv_core_pkg::word_t alu_b;
  rv_core_pkg::word_t alu_out;
  rv_core_pkg::word_t result;

  // memory stage before writeback
  // a load in the memory stage is covered by the stall
  function automatic rv_core_pkg::word_t forward(
    input rv_core_pkg::reg_addr_t rs,
    input rv_core_pkg::word_t     value
  );
    if (mem_rd_write && !mem_is_load && mem_rd == rs) return mem_result;
    if (wb_write && wb_rd == rs) return wb_data;
    return value;
  endfunction

  always_comb begin
    alu_a = ex_use_rs1 ? forward(ex_rs1, ex_op_a) : ex_op_a;
    alu_b = ex_use_rs2 ? forward(ex_rs2, ex_op_b) : ex_op_b;
  end

  always_comb begin
    case (ex_alu_op)
      rv_core_pkg::alu_add: alu_out = alu_a + alu_b;
      rv_core_pkg::alu_sub: alu_out = alu_a - alu_b;
      rv_core_pkg::alu_and: alu_out = alu_a & alu_b;
      rv_core_pkg::alu_or:  alu_out = alu_a | alu_b;
      rv_core_pkg::alu_xor: alu_out = alu_a ^ alu_b;
      rv_core_pkg::alu_slt: alu_out = {63'd0, $signed(alu_a) < $signed(alu_b)};
      default:              alu_out = alu_b;
    endcase
  end

  // loads and stores address off rs1 plus immediate
  always_comb begin
    if (ex_is_jal) begin
      result = ex_pc + 64'd4;
    end else if (ex_is_load || ex_is_store) begin
      result = alu_a + ex_imm;
    end else begin
      result = alu_out;
    end
  end

  assign redirect = ex_is_jal || (ex_is_branch && ((alu_a == alu_b) != ex_branch_ne));
  assign redirect_pc = ex_pc + ex_imm;

  always_ff @(posedge clock) begin
    if (reset) begin
      mem_valid <= 1'b0;
      mem_rd_write <= 1'b0;
      mem_is_load <= 1'b0;
      mem_is_store <= 1'b0;
    end else begin
      mem_valid <= ex_valid;
      mem_rd_write <= ex_rd_write;
      mem_is_load <= ex_is_load;
      mem_is_store <= ex_is_store;
    end
  end

  always_ff @(posedge clock) begin
    mem_pc <= ex_pc;
    mem_rd <= ex_rd;
    mem_result <= result;
    mem_store_data <= alu_b;
  end

endmodule

`default_nettype wire

// File: source/memory_writeback.sv
//--------------------------------------
// memory and writeback
// data memory, writeback register and
// the commit report
//--------------------------------------
`timescale 1ns/1ns
`default_nettype none

module memory_writeback #(
  parameter int dmem_words = 256
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   mem_valid,
  input  rv_core_pkg::word_t     mem_pc,
  input  rv_core_pkg::reg_addr_t mem_rd,
  input  logic                   mem_rd_write,
  input  logic                   mem_is_load,
  input  logic                   mem_is_store,
  input  rv_core_pkg::word_t     mem_result,
  input  rv_core_pkg::word_t     mem_store_data,
  output logic                   wb_write,
  output rv_core_pkg::reg_addr_t wb_rd,
  output rv_core_pkg::word_t     wb_data,
  output logic                   commit_valid,
  output rv_core_pkg::word_t     commit_pc,
  output rv_core_pkg::reg_addr_t commit_rd,
  output rv_core_pkg::word_t     commit_data,
  output logic                   commit_store
);

  localparam int dmem_aw = $clog2(dmem_words);

  rv_core_pkg::word_t dmem [dmem_words];
  rv_core_pkg::word_t load_data;
  logic [dmem_aw-1:0] dmem_index;

  // doubleword addressing
  assign dmem_index = mem_result[dmem_aw+2:3];
  assign load_data = dmem[dmem_index];

  always_ff @(posedge clock) begin
    if (mem_is_store) begin
      dmem[dmem_index] <= mem_store_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      commit_valid <= 1'b0;
      wb_write <= 1'b0;
      commit_store <= 1'b0;
    end else begin
      commit_valid <= mem_valid;
      wb_write <= mem_rd_write;
      commit_store <= mem_is_store;
    end
  end

  // non-writers report rd x0 and zero data
  always_ff @(posedge clock) begin
    commit_pc <= mem_pc;
    wb_rd <= mem_rd_write ? mem_rd : 5'd0;
    if (mem_is_store) begin
      wb_data <= mem_store_data;
    end else if (!mem_rd_write) begin
      wb_data <= '0;
    end else begin
      wb_data <= mem_is_load ? load_data : mem_result;
    end
  end

  assign commit_rd = wb_rd;
  assign commit_data = wb_data;

endmodule

`default_nettype wire

// File: source/rv_core.sv
//--------------------------------------
// rv_core
// five-stage rv64i integer pipeline
//--------------------------------------
`timescale 1ns/1ns
`default_nettype none

module rv_core #(
  parameter int imem_words = 256,
  parameter int dmem_words = 256,
  parameter rv_core_pkg::word_t reset_pc = '0
) (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          prog_write,
  input  logic [$clog2(imem_words)-1:0] prog_addr,
  input  logic [31:0]                   prog_data,
  input  logic                          run,
  output logic                          commit_valid,
  output rv_core_pkg::word_t            commit_pc,
  output rv_core_pkg::reg_addr_t        commit_rd,
  output rv_core_pkg::word_t            commit_data,
  output logic                          commit_store
);

  logic fetch_valid;
  rv_core_pkg::word_t fetch_pc;
  rv_core_pkg::instr_t fetch_instr;
  logic stall;
  logic redirect;
  rv_core_pkg::word_t redirect_pc;

  rv_core_pkg::reg_addr_t rs1;
  rv_core_pkg::reg_addr_t rs2;
  rv_core_pkg::word_t rs1_data;
  rv_core_pkg::word_t rs2_data;

  logic ex_valid;
  rv_core_pkg::word_t ex_pc;
  rv_core_pkg::alu_op_t ex_alu_op;
  rv_core_pkg::word_t ex_op_a;
  rv_core_pkg::word_t ex_op_b;
  rv_core_pkg::word_t ex_imm;
  logic ex_use_rs1;
  logic ex_use_rs2;
  rv_core_pkg::reg_addr_t ex_rs1;
  rv_core_pkg::reg_addr_t ex_rs2;
  rv_core_pkg::reg_addr_t ex_rd;
  logic ex_rd_write;
  logic ex_is_load;
  logic ex_is_store;
  logic ex_is_branch;
  logic ex_branch_ne;
  logic ex_is_jal;

  logic mem_valid;
  rv_core_pkg::word_t mem_pc;
  rv_core_pkg::reg_addr_t mem_rd;
  logic mem_rd_write;
  logic mem_is_load;
  logic mem_is_store;
  rv_core_pkg::word_t mem_result;
  rv_core_pkg::word_t mem_store_data;

  logic wb_write;
  rv_core_pkg::reg_addr_t wb_rd;
  rv_core_pkg::word_t wb_data;

  fetch_unit #(
    .imem_words (imem_words),
    .reset_pc   (reset_pc)
  ) fetch_unit_i (
    .clock       (clock),
    .reset       (reset),
    .run         (run),
    .prog_write  (prog_write),
    .prog_addr   (prog_addr),
    .prog_data   (prog_data),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .fetch_valid (fetch_valid),
    .fetch_pc    (fetch_pc),
    .fetch_instr (fetch_instr)
  );

  register_file register_file_i (
    .clock    (clock),
    .reset    (reset),
    .rs1      (rs1),
    .rs2      (rs2),
    .wb_write (wb_write),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  decode_unit decode_unit_i (
    .clock        (clock),
    .reset        (reset),
    .fetch_valid  (fetch_valid),
    .fetch_pc     (fetch_pc),
    .fetch_instr  (fetch_instr),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .redirect     (redirect),
    .rs1          (rs1),
    .rs2          (rs2),
    .stall        (stall),
    .ex_valid     (ex_valid),
    .ex_pc        (ex_pc),
    .ex_alu_op    (ex_alu_op),
    .ex_op_a      (ex_op_a),
    .ex_op_b      (ex_op_b),
    .ex_imm       (ex_imm),
    .ex_use_rs1   (ex_use_rs1),
    .ex_use_rs2   (ex_use_rs2),
    .ex_rs1       (ex_rs1),
    .ex_rs2       (ex_rs2),
    .ex_rd        (ex_rd),
    .ex_rd_write  (ex_rd_write),
    .ex_is_load   (ex_is_load),
    .ex_is_store  (ex_is_store),
    .ex_is_branch (ex_is_branch),
    .ex_branch_ne (ex_branch_ne),
    .ex_is_jal    (ex_is_jal)
  );

  execute_unit execute_unit_i (
    .clock          (clock),
    .reset          (reset),
    .ex_valid       (ex_valid),
    .ex_pc          (ex_pc),
    .ex_alu_op      (ex_alu_op),
    .ex_op_a        (ex_op_a),
    .ex_op_b        (ex_op_b),
    .ex_imm         (ex_imm),
    .ex_use_rs1     (ex_use_rs1),
    .ex_use_rs2     (ex_use_rs2),
    .ex_rs1         (ex_rs1),
    .ex_rs2         (ex_rs2),
    .ex_rd          (ex_rd),
    .ex_rd_write    (ex_rd_write),
    .ex_is_load     (ex_is_load),
    .ex_is_store    (ex_is_store),
    .ex_is_branch   (ex_is_branch),
    .ex_branch_ne   (ex_branch_ne),
    .ex_is_jal      (ex_is_jal),
    .wb_write       (wb_write),
    .wb_rd          (wb_rd),
    .wb_data        (wb_data),
    .redirect       (redirect),
    .redirect_pc    (redirect_pc),
    .mem_valid      (mem_valid),
    .mem_pc         (mem_pc),
    .mem_rd         (mem_rd),
    .mem_rd_write   (mem_rd_write),
    .mem_is_load    (mem_is_load),
    .mem_is_store   (mem_is_store),
    .mem_result     (mem_result),
    .mem_store_data (mem_store_data)
  );

  memory_writeback #(
    .dmem_words (dmem_words)
  ) memory_writeback_i (
    .clock          (clock),
    .reset          (reset),
    .mem_valid      (mem_valid),
    .mem_pc         (mem_pc),
    .mem_rd         (mem_rd),
    .mem_rd_write   (mem_rd_write),
    .mem_is_load    (mem_is_load),
    .mem_is_store   (mem_is_store),
    .mem_result     (mem_result),
    .mem_store_data (mem_store_data),
    .wb_write       (wb_write),
    .wb_rd          (wb_rd),
    .wb_data        (wb_data),
    .commit_valid   (commit_valid),
    .commit_pc      (commit_pc),
    .commit_rd      (commit_rd),
    .commit_data    (commit_data),
    .commit_store   (commit_store)
  );

endmodule

`default_nettype wire

// File: bench/rv_core_assertions.sv
//--------------------------------------
// rv_core pipeline checks
// bound into decode and execute
//--------------------------------------
`timescale 1ns/1ns
`default_nettype none

module rv_core_assertions (
  input logic                   clock,
  input logic                   reset,
  input logic                   stall,
  input logic                   redirect,
  input logic                   valid,
  input logic                   rf_write,
  input rv_core_pkg::reg_addr_t rf_rd
);

  // count of failed checks
  int failures = 0;

  stall_single_cycle: assert property (
    @(posedge clock) disable iff (reset) stall |=> !stall
  ) else begin
    $error("stall held for two consecutive cycles");
    failures++;
  end

  redirect_single_cycle: assert property (
    @(posedge clock) disable iff (reset) redirect |=> !redirect
  ) else begin
    $error("redirect high in two consecutive cycles");
    failures++;
  end

  valid_low_after_reset: assert property (
    @(posedge clock) reset |=> !valid
  ) else begin
    $error("valid bit high in the cycle after reset");
    failures++;
  end

  no_x0_write: assert property (
    @(posedge clock) disable iff (reset) rf_write |-> rf_rd != 5'd0
  ) else begin
    $error("register file write aimed at x0");
    failures++;
  end

endmodule

bind decode_unit rv_core_assertions decode_checks_i (
  .clock    (clock),
  .reset    (reset),
  .stall    (stall),
  .redirect (redirect),
  .valid    (ex_valid),
  .rf_write (1'b0),
  .rf_rd    (5'd0)
);

// write port seen through the forwarding inputs
bind execute_unit rv_core_assertions execute_checks_i (
  .clock    (clock),
  .reset    (reset),
  .stall    (1'b0),
  .redirect (redirect),
  .valid    (mem_valid),
  .rf_write (wb_write),
  .rf_rd    (wb_rd)
);

`default_nettype wire

// File: bench/rv_core_tb.sv
//--------------------------------------
// rv_core testbench
// loads a program from the pattern file
// and checks every commit in order
//--------------------------------------
`timescale 1ns/1ns
`default_nettype none

module rv_core_tb;

  localparam int imem_words = 256;
  localparam int dmem_words = 256;
  localparam int imem_aw = $clog2(imem_words);
  localparam int commit_timeout = 200;

  logic clock;
  logic reset;
  logic prog_write;
  logic [imem_aw-1:0] prog_addr;
  logic [31:0] prog_data;
  logic run;
  logic commit_valid;
  rv_core_pkg::word_t commit_pc;
  rv_core_pkg::reg_addr_t commit_rd;
  rv_core_pkg::word_t commit_data;
  logic commit_store;

  logic [imem_aw-1:0] prog_index_q[$];
  logic [31:0] prog_word_q[$];
  rv_core_pkg::word_t exp_pc_q[$];
  rv_core_pkg::reg_addr_t exp_rd_q[$];
  rv_core_pkg::word_t exp_data_q[$];
  logic exp_store_q[$];

  rv_core #(
    .imem_words (imem_words),
    .dmem_words (dmem_words),
    .reset_pc   (64'd0)
  ) dut_i (
    .clock        (clock),
    .reset        (reset),
    .prog_write   (prog_write),
    .prog_addr    (prog_addr),
    .prog_data    (prog_data),
    .run          (run),
    .commit_valid (commit_valid),
    .commit_pc    (commit_pc),
    .commit_rd    (commit_rd),
    .commit_data  (commit_data),
    .commit_store (commit_store)
  );

  always #5 clock = ~clock;

  task automatic stop_run();
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(input string name, input rv_core_pkg::word_t expected,
                            input rv_core_pkg::word_t actual);
    if (actual !== expected) begin
      $display("ERROR %s expected %h actual %h", name, expected, actual);
      stop_run();
    end
  endtask

  task automatic check_reg(input string name, input rv_core_pkg::reg_addr_t expected,
                           input rv_core_pkg::reg_addr_t actual);
    if (actual !== expected) begin
      $display("ERROR %s expected x%0d actual x%0d", name, expected, actual);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("ERROR %s expected %b actual %b", name, expected, actual);
      stop_run();
    end
  endtask

  // tagged lines, anything after the fields is a comment
  task automatic read_patterns();
    int fd;
    int code;
    logic [63:0] tag;
    logic [8*128-1:0] rest;
    logic [imem_aw-1:0] index;
    logic [31:0] instr;
    rv_core_pkg::word_t pc;
    rv_core_pkg::reg_addr_t rd;
    rv_core_pkg::word_t data;
    logic store;
    fd = $fopen("bench/rv_core_patterns.txt", "r");
    if (fd == 0) begin
      $display("cannot open the pattern file bench/rv_core_patterns.txt");
      stop_run();
    end
    tag = '0;
    code = $fscanf(fd, "%s", tag);
    while (code == 1) begin
      if (tag == "P") begin
        code = $fscanf(fd, "%h %h", index, instr);
        if (code != 2) begin
          $display("malformed program line in the pattern file");
          stop_run();
        end
        prog_index_q.push_back(index);
        prog_word_q.push_back(instr);
      end else if (tag == "C") begin
        code = $fscanf(fd, "%h %h %h %h", pc, rd, data, store);
        if (code != 4) begin
          $display("malformed commit line in the pattern file");
          stop_run();
        end
        exp_pc_q.push_back(pc);
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(data);
        exp_store_q.push_back(store);
      end else if (tag != "#") begin
        $display("unknown line tag in the pattern file");
        stop_run();
      end
      code = $fgets(rest, fd);
      tag = '0;
      code = $fscanf(fd, "%s", tag);
    end
    $fclose(fd);
  endtask

  task automatic load_program();
    for (int n = 0; n < prog_word_q.size(); n++) begin
      @(posedge clock);
      prog_write <= 1'b1;
      prog_addr <= prog_index_q[n];
      prog_data <= prog_word_q[n];
      @(negedge clock);
      check_bit("commit_valid while loading", 1'b0, commit_valid);
    end
    @(posedge clock);
    prog_write <= 1'b0;
  endtask

  task automatic wait_for_commit(input int number);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clock);
      cycles++;
    end while (!commit_valid && cycles < commit_timeout);
    if (!commit_valid) begin
      $display("no commit within %0d cycles while waiting for commit %0d",
               commit_timeout, number);
      stop_run();
    end
  endtask

  task automatic compare_commit(input int number);
    check_word($sformatf("commit %0d pc", number), exp_pc_q[number], commit_pc);
    check_reg($sformatf("commit %0d rd", number), exp_rd_q[number], commit_rd);
    check_word($sformatf("commit %0d data", number), exp_data_q[number], commit_data);
    check_bit($sformatf("commit %0d store", number), exp_store_q[number], commit_store);
  endtask

  initial begin
    int assert_failures;
    clock = 1'b0;
    reset = 1'b1;
    prog_write = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    run = 1'b0;
    read_patterns();
    if (exp_pc_q.size() == 0) begin
      $display("the pattern file holds no expected commits");
      stop_run();
    end
    // two reset cycles
    @(posedge clock);
    @(negedge clock);
    check_bit("commit_valid in reset", 1'b0, commit_valid);
    @(posedge clock);
    reset <= 1'b0;
    load_program();
    repeat (4) begin
      @(negedge clock);
      check_bit("commit_valid before run", 1'b0, commit_valid);
    end
    @(posedge clock);
    run <= 1'b1;
    for (int n = 0; n < exp_pc_q.size(); n++) begin
      wait_for_commit(n);
      compare_commit(n);
    end
    assert_failures = dut_i.decode_unit_i.decode_checks_i.failures +
                      dut_i.execute_unit_i.execute_checks_i.failures;
    if (assert_failures == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("%0d pipeline assertion failures during the run", assert_failures);
      stop_run();
    end
  end

endmodule

`default_nettype wire

// File: rv_core.f
source/rv_core_pkg.sv
source/fetch_unit.sv
source/register_file.sv
source/decode_unit.sv
source/execute_unit.sv
source/memory_writeback.sv
source/rv_core.sv
bench/rv_core_assertions.sv
bench/rv_core_tb.sv

// File: bench/rv_core_patterns.txt
# P <imem word index> <instruction word>
# C <pc> <rd> <rd or store data> <store flag>, all fields hex

# dependent alu chain
P 00 123450b7  # lui  x1, 0x12345
P 01 67808113  # addi x2, x1, 0x678
P 02 002081b3  # add  x3, x1, x2
P 03 40118233  # sub  x4, x3, x1
P 04 003242b3  # xor  x5, x4, x3
P 05 0051a333  # slt  x6, x3, x5
P 06 fff00393  # addi x7, x0, -1
P 07 0063a433  # slt  x8, x7, x6
P 08 0f03f493  # andi x9, x7, 0xf0
P 09 00f4e513  # ori  x10, x9, 0xf
P 0a 7ff54593  # xori x11, x10, 0x7ff
P 0b 7015a613  # slti x12, x11, 0x701
# store, load and a dependent add
P 0c 04000693  # addi x13, x0, 0x40
P 0d 0056b423  # sd   x5, 8(x13)
P 0e 0086b703  # ld   x14, 8(x13)
P 0f 001707b3  # add  x15, x14, x1
# taken beq over two words, bne falls through
P 10 00220663  # beq  x4, x2, +12
P 11 00100813  # addi x16, x0, 1
P 12 00200893  # addi x17, x0, 2
P 13 00949463  # bne  x9, x9, +8
P 14 05500913  # addi x18, x0, 0x55
# jal with link, then the self-loop
P 15 00c009ef  # jal  x19, +12
P 16 00300a13  # addi x20, x0, 3
P 17 00400a93  # addi x21, x0, 4
P 18 01298b33  # add  x22, x19, x18
P 19 0000006f  # jal  x0, 0
P 1a 00000013  # nop
P 1b 00000013  # nop

C 00000000 01 0000000012345000 0
C 00000004 02 0000000012345678 0
C 00000008 03 000000002468a678 0
C 0000000c 04 0000000012345678 0
C 00000010 05 00000000365cf000 0
C 00000014 06 0000000000000001 0
C 00000018 07 ffffffffffffffff 0
C 0000001c 08 0000000000000001 0
C 00000020 09 00000000000000f0 0
C 00000024 0a 00000000000000ff 0
C 00000028 0b 0000000000000700 0
C 0000002c 0c 0000000000000001 0
C 00000030 0d 0000000000000040 0
C 00000034 00 00000000365cf000 1
C 00000038 0e 00000000365cf000 0
C 0000003c 0f 0000000048914000 0
C 00000040 00 0000000000000000 0
C 0000004c 00 0000000000000000 0
C 00000050 12 0000000000000055 0
C 00000054 13 0000000000000058 0
C 00000060 16 00000000000000ad 0
C 00000064 00 0000000000000000 0
